// File: verilog/denoise_defs.svh
//********************************************************************
// Widths, block geometry and register map of the block denoiser.
// Include wherever a size or a register address is needed; the
// guard makes repeated includes harmless.
//********************************************************************
`ifndef DENOISE_DEFS_SVH
`define DENOISE_DEFS_SVH

// Stream word and one colour channel
`define DN_PIX_W	32
`define DN_CH_W	8

// 8x8 block
`define DN_BLK_PIX	64
`define DN_BLK_LOG2	6

`define DN_VAR_W	16
// Gain is unsigned fixed point, unity is 1 << DN_GAIN_FRAC
`define DN_GAIN_FRAC	8

// AXI-lite bus and register addresses
`define DN_LITE_ADDR_W	2
`define DN_LITE_DATA_W	16
`define DN_REG_WIDTH	0
`define DN_REG_HEIGHT	1
`define DN_REG_NOISE	2

`endif

// File: verilog/denoise_pkg.sv
//********************************************************************
// Types shared by the denoiser blocks: the stream pixel word, the
// frame configuration and the per-block statistics record.
// Modules import it with a wildcard in their header.
//********************************************************************
`include "denoise_defs.svh"

package denoise_pkg;

	// Colours sit in the low 24 bits
	typedef struct packed {
		logic [`DN_CH_W-1:0] pad;
		logic [`DN_CH_W-1:0] r;
		logic [`DN_CH_W-1:0] g;
		logic [`DN_CH_W-1:0] b;
	} rgb_t;

	// Raw word in the block buffer, channels in the datapath
	typedef union packed {
		logic [`DN_PIX_W-1:0] raw;
		rgb_t ch;
	} pixel_u;

	typedef struct packed {
		logic [`DN_LITE_DATA_W-1:0] width;
		logic [`DN_LITE_DATA_W-1:0] height;
		logic [2*`DN_LITE_DATA_W-`DN_BLK_LOG2-1:0] blocks_per_frame;
	} frame_cfg_t;

	// valid is a single-cycle pulse per finished block
	typedef struct packed {
		logic valid;
		logic first_of_frame;
		logic last_of_frame;
		logic [`DN_VAR_W-1:0] luma_var;
		logic [`DN_CH_W-1:0] mean_r;
		logic [`DN_CH_W-1:0] mean_g;
		logic [`DN_CH_W-1:0] mean_b;
	} block_stats_t;

endpackage

// File: verilog/denoise_regs.sv
//********************************************************************
// AXI-lite slave with the frame size registers and a read-only view
// of the current noise level. Width and height feed the block count
// used by the statistics block.
//********************************************************************
`include "denoise_defs.svh"

module denoise_regs import denoise_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic [`DN_LITE_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DN_LITE_DATA_W-1:0] wdata,
	input  logic [`DN_LITE_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`DN_LITE_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DN_LITE_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic [`DN_VAR_W-1:0] noise_level,
	output frame_cfg_t cfg
);
	localparam int BPF_W = 2*`DN_LITE_DATA_W - `DN_BLK_LOG2;

	logic wr_accept;
	logic rd_accept;
	logic [`DN_LITE_DATA_W-1:0] width_q;
	logic [`DN_LITE_DATA_W-1:0] height_q;
	logic [`DN_LITE_DATA_W-1:0] rd_word;
	logic [2*`DN_LITE_DATA_W-1:0] pix_per_frame;
	logic [BPF_W-1:0] bpf_q;

	// Write needs address and data together, one response outstanding
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign rd_accept = arvalid && !rvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// Byte lanes merged under wstrb
	function automatic logic [`DN_LITE_DATA_W-1:0] merge(
		input logic [`DN_LITE_DATA_W-1:0] old,
		input logic [`DN_LITE_DATA_W-1:0] data,
		input logic [`DN_LITE_DATA_W/8-1:0] strb
	);
		logic [`DN_LITE_DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < `DN_LITE_DATA_W/8; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			width_q <= '0;
			height_q <= '0;
			bvalid <= 1'b0;
		end else if (wr_accept) begin
			bvalid <= 1'b1;
			case (awaddr)
				`DN_REG_WIDTH: width_q <= merge(width_q, wdata, wstrb);
				`DN_REG_HEIGHT: height_q <= merge(height_q, wdata, wstrb);
				default: ;
			endcase
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// Noise register is read only
	always_comb begin
		case (araddr)
			`DN_REG_WIDTH: rd_word = width_q;
			`DN_REG_HEIGHT: rd_word = height_q;
			`DN_REG_NOISE: rd_word = noise_level;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			rdata <= '0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
			rdata <= rd_word;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Whole blocks per frame, at least one
	assign pix_per_frame = width_q * height_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bpf_q <= BPF_W'(1);
		else if (pix_per_frame[2*`DN_LITE_DATA_W-1:`DN_BLK_LOG2] == '0)
			bpf_q <= BPF_W'(1);
		else
			bpf_q <= pix_per_frame[2*`DN_LITE_DATA_W-1:`DN_BLK_LOG2];
	end

	assign cfg.width = width_q;
	assign cfg.height = height_q;
	assign cfg.blocks_per_frame = bpf_q;

	// Read response held until the master takes it
	assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: verilog/block_stats.sv
//********************************************************************
// Per-block statistics over 64 accepted pixels: luma mean and
// variance plus the three channel means, with frame start and end
// flags. Results are presented with a one-cycle valid pulse.
//********************************************************************
`include "denoise_defs.svh"

module block_stats import denoise_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic pix_valid,
	input  pixel_u pix,
	input  logic pix_first,
	input  frame_cfg_t cfg,
	output block_stats_t stats
);
	localparam int SUM_W = `DN_CH_W + `DN_BLK_LOG2;
	localparam int SQ_W = 2*`DN_CH_W + `DN_BLK_LOG2;

	logic [`DN_CH_W+1:0] ch_sum;
	logic [`DN_CH_W-1:0] luma;
	logic [2*`DN_CH_W-1:0] luma_sq;
	logic [`DN_BLK_LOG2-1:0] pix_cnt;
	logic blk_start;
	logic blk_end;
	logic [SUM_W-1:0] luma_acc;
	logic [SUM_W-1:0] r_acc;
	logic [SUM_W-1:0] g_acc;
	logic [SUM_W-1:0] b_acc;
	logic [SQ_W-1:0] sq_acc;
	logic [$bits(cfg.blocks_per_frame)-1:0] blk_cnt;
	logic [$bits(cfg.blocks_per_frame)-1:0] blk_next;
	logic valid_q;
	logic first_q;
	logic last_q;
	logic [`DN_CH_W-1:0] luma_mean;
	logic [2*`DN_CH_W-1:0] mean_sq;
	logic [`DN_VAR_W:0] var_full;

	// Luma is the floor of the channel average
	assign ch_sum = pix.ch.r + pix.ch.g + pix.ch.b;
	assign luma = `DN_CH_W'(ch_sum / 3);
	assign luma_sq = luma * luma;

	assign blk_start = pix_valid && (pix_cnt == '0);
	assign blk_end = pix_valid && (pix_cnt == '1);
	assign blk_next = blk_cnt + 1'b1;

	// First pixel of a block reloads the sums
	always_ff @(posedge clk) begin
		if (blk_start) begin
			luma_acc <= SUM_W'(luma);
			sq_acc <= SQ_W'(luma_sq);
			r_acc <= SUM_W'(pix.ch.r);
			g_acc <= SUM_W'(pix.ch.g);
			b_acc <= SUM_W'(pix.ch.b);
		end else if (pix_valid) begin
			luma_acc <= luma_acc + luma;
			sq_acc <= sq_acc + luma_sq;
			r_acc <= r_acc + pix.ch.r;
			g_acc <= g_acc + pix.ch.g;
			b_acc <= b_acc + pix.ch.b;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt <= '0;
			blk_cnt <= '0;
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			valid_q <= blk_end;
			if (pix_valid)
				pix_cnt <= pix_cnt + 1'b1;
			if (blk_start) begin
				first_q <= pix_first;
				// tuser restarts the block count
				if (pix_first)
					blk_cnt <= '0;
			end
			if (blk_end) begin
				last_q <= (blk_next == cfg.blocks_per_frame);
				blk_cnt <= (blk_next == cfg.blocks_per_frame) ? '0 : blk_next;
			end
		end
	end

	// Sums stay put during the pulse, so the results are plain logic
	assign luma_mean = luma_acc[SUM_W-1:`DN_BLK_LOG2];
	assign mean_sq = luma_mean * luma_mean;
	assign var_full = sq_acc[SQ_W-1:`DN_BLK_LOG2] - mean_sq;

	assign stats.valid = valid_q;
	assign stats.first_of_frame = first_q;
	assign stats.last_of_frame = last_q;
	assign stats.luma_var = var_full[`DN_VAR_W] ? '1 : var_full[`DN_VAR_W-1:0];
	assign stats.mean_r = r_acc[SUM_W-1:`DN_BLK_LOG2];
	assign stats.mean_g = g_acc[SUM_W-1:`DN_BLK_LOG2];
	assign stats.mean_b = b_acc[SUM_W-1:`DN_BLK_LOG2];

	// Blocks are 64 pixels, never back to back pulses
	assert property (@(posedge clk) disable iff (!arst_n)
		stats.valid |=> !stats.valid);

endmodule

// File: verilog/noise_estimator.sv
//********************************************************************
// Frame noise estimate as the smallest block luma variance seen in
// a frame. The level is updated once per frame, after the last
// block's statistics, and holds until the next frame ends.
//********************************************************************
`include "denoise_defs.svh"

module noise_estimator import denoise_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  block_stats_t stats,
	output logic [`DN_VAR_W-1:0] noise_level
);
	logic [`DN_VAR_W-1:0] min_q;
	logic [`DN_VAR_W-1:0] min_next;

	// Running minimum, restarted by the first block of a frame
	always_comb begin
		if (stats.first_of_frame || (stats.luma_var < min_q))
			min_next = stats.luma_var;
		else
			min_next = min_q;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			min_q <= '0;
			noise_level <= '0;
		end else if (stats.valid) begin
			min_q <= min_next;
			// A one-block frame is both first and last
			if (stats.last_of_frame)
				noise_level <= min_next;
		end
	end

endmodule

// File: verilog/wiener_filter.sv
//********************************************************************
// Wiener filter over one 8x8 block at a time. Buffers the block,
// derives a luma gain with a 16-step divider once the statistics
// arrive, then streams each pixel pulled toward its channel means.
//********************************************************************
`include "denoise_defs.svh"

module wiener_filter import denoise_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  pixel_u s_axis_tdata,
	input  logic s_axis_tvalid,
	input  logic s_axis_tuser,
	output logic s_axis_tready,
	input  block_stats_t stats,
	input  logic [`DN_VAR_W-1:0] noise_level,
	output pixel_u m_axis_tdata,
	output logic m_axis_tvalid,
	output logic m_axis_tlast,
	output logic m_axis_tuser,
	input  logic m_axis_tready
);
	localparam int GAIN_W = `DN_GAIN_FRAC + 1;

	typedef enum logic [1:0] {FILL, WAIT_STATS, DIVIDE, EMIT} state_t;

	state_t state;
	logic [`DN_PIX_W-1:0] blk_buf [`DN_BLK_PIX];
	logic [`DN_BLK_LOG2-1:0] wr_idx;
	logic [`DN_BLK_LOG2-1:0] rd_idx;
	logic issued_all;
	logic user_q;
	logic [`DN_VAR_W-1:0] frame_noise;
	logic [`DN_VAR_W-1:0] noise_use;
	logic [`DN_VAR_W-1:0] var_q;
	logic [`DN_VAR_W-1:0] rem;
	logic [`DN_VAR_W:0] rem_sh;
	logic [`DN_VAR_W-1:0] quo;
	logic [$clog2(`DN_VAR_W)-1:0] div_cnt;
	logic int_bit;
	logic zero_gain;
	logic [GAIN_W-1:0] gain;
	rgb_t mean_q;
	pixel_u rd_pix;
	pixel_u filt_pix;
	logic out_adv;

	// mean + (gain * (x - mean)) >>> frac, clamped to a byte
	function automatic logic [`DN_CH_W-1:0] filt_ch(
		input logic [`DN_CH_W-1:0] x,
		input logic [`DN_CH_W-1:0] m,
		input logic [GAIN_W-1:0] g
	);
		logic signed [`DN_CH_W+1:0] diff;
		logic signed [2*`DN_CH_W+3:0] prod;
		logic signed [`DN_CH_W+3:0] res;
		diff = $signed({2'b00, x}) - $signed({2'b00, m});
		prod = diff * $signed({1'b0, g});
		res = $signed({4'b0000, m}) + $signed(prod[2*`DN_CH_W+3:`DN_GAIN_FRAC]);
		if (res < 0)
			return '0;
		if (res > $signed({4'b0000, {`DN_CH_W{1'b1}}}))
			return '1;
		return res[`DN_CH_W-1:0];
	endfunction

	assign s_axis_tready = (state == FILL);
	// First block of a frame already uses the freshly sampled level
	assign noise_use = stats.first_of_frame ? noise_level : frame_noise;
	assign rem_sh = {rem, 1'b0};
	assign gain = zero_gain ? '0 : {int_bit, quo[`DN_VAR_W-1 -: `DN_GAIN_FRAC]};
	assign rd_pix.raw = blk_buf[rd_idx];
	assign out_adv = !m_axis_tvalid || m_axis_tready;

	always_comb begin
		filt_pix.ch.pad = '0;
		filt_pix.ch.r = filt_ch(rd_pix.ch.r, mean_q.r, gain);
		filt_pix.ch.g = filt_ch(rd_pix.ch.g, mean_q.g, gain);
		filt_pix.ch.b = filt_ch(rd_pix.ch.b, mean_q.b, gain);
	end

	always_ff @(posedge clk) begin
		if (s_axis_tvalid)
			blk_buf[wr_idx] <= s_axis_tdata.raw;
	end

	// Restoring divide of (var - noise) / var into 16 fraction bits,
	// the integer bit covers the noise == 0 case
	always_ff @(posedge clk) begin
		if (stats.valid) begin
			var_q <= stats.luma_var;
			mean_q <= '{pad: '0, r: stats.mean_r, g: stats.mean_g, b: stats.mean_b};
			zero_gain <= (stats.luma_var <= noise_use);
			int_bit <= (noise_use == '0);
			rem <= (noise_use == '0) ? '0 : stats.luma_var - noise_use;
			quo <= '0;
		end else if (state == DIVIDE) begin
			if (rem_sh >= {1'b0, var_q}) begin
				rem <= `DN_VAR_W'(rem_sh - {1'b0, var_q});
				quo <= {quo[`DN_VAR_W-2:0], 1'b1};
			end else begin
				rem <= rem_sh[`DN_VAR_W-1:0];
				quo <= {quo[`DN_VAR_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == EMIT) && out_adv && !issued_all)
			m_axis_tdata <= filt_pix;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FILL;
			wr_idx <= '0;
			rd_idx <= '0;
			div_cnt <= '0;
			issued_all <= 1'b0;
			user_q <= 1'b0;
			frame_noise <= '0;
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
			m_axis_tuser <= 1'b0;
		end else begin
			if (stats.valid && stats.first_of_frame)
				frame_noise <= noise_level;
			case (state)
				FILL: begin
					if (s_axis_tvalid) begin
						wr_idx <= wr_idx + 1'b1;
						if (wr_idx == '0)
							user_q <= s_axis_tuser;
						if (wr_idx == '1)
							state <= WAIT_STATS;
					end
				end
				WAIT_STATS: begin
					if (stats.valid)
						state <= DIVIDE;
				end
				DIVIDE: begin
					// Counter wraps to zero for the next block
					div_cnt <= div_cnt + 1'b1;
					if (div_cnt == '1) begin
						issued_all <= 1'b0;
						state <= EMIT;
					end
				end
				EMIT: begin
					if (out_adv) begin
						m_axis_tvalid <= !issued_all;
						if (!issued_all) begin
							m_axis_tlast <= (rd_idx == '1);
							m_axis_tuser <= user_q && (rd_idx == '0);
							rd_idx <= rd_idx + 1'b1;
							issued_all <= (rd_idx == '1);
						end
					end
					if (m_axis_tvalid && m_axis_tready && m_axis_tlast)
						state <= FILL;
				end
				default: state <= FILL;
			endcase
		end
	end

	// Top masks the input strobe with tready, so a full buffer sees nothing
	assert property (@(posedge clk) disable iff (!arst_n)
		s_axis_tvalid |-> state == FILL);

	assert property (@(posedge clk) disable iff (!arst_n)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata));

endmodule

// File: verilog/denoise_top.sv
//********************************************************************
// Top level of the block denoiser. Block-ordered pixels come in on
// an AXI stream, filtered pixels leave on another, and frame size
// and noise readback sit behind an AXI-lite slave.
//********************************************************************
`include "denoise_defs.svh"

module denoise_top import denoise_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic [`DN_LITE_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DN_LITE_DATA_W-1:0] wdata,
	input  logic [`DN_LITE_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`DN_LITE_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DN_LITE_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic [`DN_PIX_W-1:0] s_axis_tdata,
	input  logic s_axis_tvalid,
	// Block ends come from the pixel count, tlast is not needed
	input  logic s_axis_tlast,
	input  logic s_axis_tuser,
	output logic s_axis_tready,
	output logic [`DN_PIX_W-1:0] m_axis_tdata,
	output logic m_axis_tvalid,
	output logic m_axis_tlast,
	output logic m_axis_tuser,
	input  logic m_axis_tready
);
	logic pix_acc;
	pixel_u pix_in;
	pixel_u pix_out;
	frame_cfg_t cfg;
	block_stats_t stats;
	logic [`DN_VAR_W-1:0] noise_level;

	// Both consumers see only accepted pixels
	assign pix_acc = s_axis_tvalid && s_axis_tready;
	assign pix_in.raw = s_axis_tdata;
	assign m_axis_tdata = pix_out.raw;

	denoise_regs denoise_regs_i (
		.clk(clk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.noise_level(noise_level), .cfg(cfg)
	);

	block_stats block_stats_i (
		.clk(clk), .arst_n(arst_n),
		.pix_valid(pix_acc), .pix(pix_in), .pix_first(s_axis_tuser),
		.cfg(cfg), .stats(stats)
	);

	noise_estimator noise_estimator_i (
		.clk(clk), .arst_n(arst_n),
		.stats(stats), .noise_level(noise_level)
	);

	wiener_filter wiener_filter_i (
		.clk(clk), .arst_n(arst_n),
		.s_axis_tdata(pix_in), .s_axis_tvalid(pix_acc),
		.s_axis_tuser(s_axis_tuser), .s_axis_tready(s_axis_tready),
		.stats(stats), .noise_level(noise_level),
		.m_axis_tdata(pix_out), .m_axis_tvalid(m_axis_tvalid),
		.m_axis_tlast(m_axis_tlast), .m_axis_tuser(m_axis_tuser),
		.m_axis_tready(m_axis_tready)
	);

endmodule

// File: verif/denoise_ref.svh
//********************************************************************
// Reference model of the block denoiser for the testbench: luma,
// block variance, channel means, Wiener gain, filtered pixels and
// the frame noise. Included inside the testbench module.
//********************************************************************
`ifndef DENOISE_REF_SVH
`define DENOISE_REF_SVH

// Floor of the channel average
function automatic int luma_of(input pixel_u p);
	return (int'(p.ch.r) + int'(p.ch.g) + int'(p.ch.b)) / 3;
endfunction

function automatic int luma_var_of(input pixel_u blk [`DN_BLK_PIX]);
	int sum;
	int sq;
	int mean;
	int v;
	sum = 0;
	sq = 0;
	foreach (blk[i]) begin
		sum += luma_of(blk[i]);
		sq += luma_of(blk[i]) * luma_of(blk[i]);
	end
	mean = sum / `DN_BLK_PIX;
	v = sq / `DN_BLK_PIX - mean * mean;
	// Saturate to the variance width
	if (v > (1 << `DN_VAR_W) - 1)
		v = (1 << `DN_VAR_W) - 1;
	return v;
endfunction

// sel picks r, g or b
function automatic int chan_mean(input pixel_u blk [`DN_BLK_PIX], input int sel);
	int sum;
	sum = 0;
	foreach (blk[i]) begin
		case (sel)
			0: sum += int'(blk[i].ch.r);
			1: sum += int'(blk[i].ch.g);
			default: sum += int'(blk[i].ch.b);
		endcase
	end
	return sum / `DN_BLK_PIX;
endfunction

function automatic int gain_of(input int v, input int noise);
	if (v <= noise)
		return 0;
	return ((v - noise) << `DN_GAIN_FRAC) / v;
endfunction

function automatic int filt_chan(input int x, input int m, input int g);
	int y;
	y = m + ((g * (x - m)) >>> `DN_GAIN_FRAC);
	if (y < 0)
		y = 0;
	if (y > 255)
		y = 255;
	return y;
endfunction

function automatic pixel_u filt_pixel(input pixel_u x, input rgb_t m, input int g);
	pixel_u y;
	y.raw = '0;
	y.ch.r = `DN_CH_W'(filt_chan(int'(x.ch.r), int'(m.r), g));
	y.ch.g = `DN_CH_W'(filt_chan(int'(x.ch.g), int'(m.g), g));
	y.ch.b = `DN_CH_W'(filt_chan(int'(x.ch.b), int'(m.b), g));
	return y;
endfunction

// Noise of a frame is its smallest block variance
function automatic int frame_min(input int vars [$]);
	int m;
	m = vars[0];
	foreach (vars[i])
		if (vars[i] < m)
			m = vars[i];
	return m;
endfunction

`endif

// File: verif/denoise_tb.sv
//********************************************************************
// Testbench for the block denoiser top level. Configures a 16x8
// frame over AXI-lite, streams three frames of random blocks and
// checks every output beat and the noise readback against a model.
//********************************************************************
`include "denoise_defs.svh"

module denoise_tb import denoise_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 2000;
	localparam int FLAT = 0;
	localparam int NARROW = 1;
	localparam int WIDE = 2;

	typedef struct packed {
		logic [`DN_PIX_W-1:0] data;
		logic last;
		logic user;
		logic [1:0] frame;
	} beat_t;

	typedef enum int {W_READY, B_VALID, AR_READY, R_VALID, PIX_READY, DRAINED} cond_t;

	logic clk = 1'b0;
	logic arst_n;
	logic [`DN_LITE_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`DN_LITE_DATA_W-1:0] wdata;
	logic [`DN_LITE_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`DN_LITE_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`DN_LITE_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`DN_PIX_W-1:0] s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	logic s_axis_tuser;
	logic s_axis_tready;
	logic [`DN_PIX_W-1:0] m_axis_tdata;
	logic m_axis_tvalid;
	logic m_axis_tlast;
	logic m_axis_tuser;
	logic m_axis_tready = 1'b1;

	integer seed = 32'h2a81;
	int model_noise = 0;
	int frame_beats [3];
	logic toggle_ready = 1'b0;
	logic [`DN_LITE_DATA_W-1:0] rd;
	beat_t exp_q [$];

	`include "denoise_ref.svh"

	always #5 clk = ~clk;

	denoise_top denoise_top_i (.*);

	task automatic compare_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic report_stall(input string what);
		$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	function automatic logic probe(input cond_t c);
		case (c)
			W_READY: return awready && wready;
			B_VALID: return bvalid;
			AR_READY: return arready;
			R_VALID: return rvalid;
			PIX_READY: return s_axis_tready;
			default: return exp_q.size() == 0;
		endcase
	endfunction

	// Samples at the falling edge, where DUT outputs are settled
	task automatic wait_for(input cond_t c, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				report_stall(what);
		end while (!probe(c));
	endtask

	task automatic write_reg(input logic [`DN_LITE_ADDR_W-1:0] addr,
			input logic [`DN_LITE_DATA_W-1:0] data);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= '1;
		wvalid <= 1'b1;
		wait_for(W_READY, "the AXI-lite write to be accepted");
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		wait_for(B_VALID, "the AXI-lite write response");
		compare_val("bresp", 32'(bresp), 32'(0));
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [`DN_LITE_ADDR_W-1:0] addr,
			output logic [`DN_LITE_DATA_W-1:0] data);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		wait_for(AR_READY, "the AXI-lite read to be accepted");
		@(posedge clk);
		arvalid <= 1'b0;
		rready <= 1'b1;
		wait_for(R_VALID, "the AXI-lite read data");
		data = rdata;
		compare_val("rresp", 32'(rresp), 32'(0));
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// Builds one block, queues its expected output, then streams it
	task automatic send_block(input int kind, input logic first, input logic [1:0] frame,
			output int v);
		pixel_u blk [`DN_BLK_PIX];
		pixel_u base;
		rgb_t mean;
		beat_t b;
		int g;
		// Away from the edge where the ready toggler draws numbers
		@(negedge clk);
		base.raw = $random(seed);
		foreach (blk[i]) begin
			blk[i].raw = $random(seed);
			if (kind == FLAT) begin
				blk[i] = base;
			end else if (kind == NARROW) begin
				blk[i].ch.r = {2'b01, blk[i].ch.r[5:0]};
				blk[i].ch.g = {2'b01, blk[i].ch.g[5:0]};
				blk[i].ch.b = {2'b01, blk[i].ch.b[5:0]};
			end
		end
		v = luma_var_of(blk);
		g = gain_of(v, model_noise);
		mean.pad = '0;
		mean.r = `DN_CH_W'(chan_mean(blk, 0));
		mean.g = `DN_CH_W'(chan_mean(blk, 1));
		mean.b = `DN_CH_W'(chan_mean(blk, 2));
		foreach (blk[i]) begin
			b.data = filt_pixel(blk[i], mean, g);
			b.last = (i == `DN_BLK_PIX - 1);
			b.user = first && (i == 0);
			b.frame = frame;
			exp_q.push_back(b);
		end
		@(posedge clk);
		foreach (blk[i]) begin
			s_axis_tdata <= blk[i].raw;
			s_axis_tvalid <= 1'b1;
			s_axis_tuser <= first && (i == 0);
			s_axis_tlast <= (i == `DN_BLK_PIX - 1);
			wait_for(PIX_READY, "s_axis_tready");
			@(posedge clk);
		end
		s_axis_tvalid <= 1'b0;
		s_axis_tuser <= 1'b0;
		s_axis_tlast <= 1'b0;
	endtask

	task automatic send_frame(input int kind0, input int kind1, input logic [1:0] frame);
		int vars [$];
		int v;
		send_block(kind0, 1'b1, frame, v);
		vars.push_back(v);
		send_block(kind1, 1'b0, frame, v);
		vars.push_back(v);
		// Next frame filters with this one's noise
		model_noise = frame_min(vars);
	endtask

	always @(posedge clk) begin
		if (toggle_ready)
			m_axis_tready <= ($random(seed) % 2) != 0;
		else
			m_axis_tready <= 1'b1;
	end

	// Output monitor, one beat per handshake
	always @(negedge clk) begin
		beat_t b;
		if (arst_n && m_axis_tvalid) begin
			compare_val("s_axis_tready", 32'(s_axis_tready), 32'(0));
			if (m_axis_tready) begin
				if (exp_q.size() == 0) begin
					$display("Output beat at %0t ns with no pixel expected", $time);
					$display("Testbench failed");
					$fatal(1);
				end else begin
					b = exp_q.pop_front();
					compare_val("m_axis_tdata", m_axis_tdata, b.data);
					compare_val("m_axis_tlast", 32'(m_axis_tlast), 32'(b.last));
					compare_val("m_axis_tuser", 32'(m_axis_tuser), 32'(b.user));
					frame_beats[b.frame]++;
				end
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tuser = 1'b0;
		foreach (frame_beats[f])
			frame_beats[f] = 0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		// 16x8 frame, two blocks
		write_reg(`DN_REG_WIDTH, 16);
		write_reg(`DN_REG_HEIGHT, 8);
		read_reg(`DN_REG_WIDTH, rd);
		compare_val("width", 32'(rd), 32'(16));
		read_reg(`DN_REG_HEIGHT, rd);
		compare_val("height", 32'(rd), 32'(8));

		send_frame(NARROW, WIDE, 2'd0);
		wait_for(DRAINED, "the output of frame 1");
		read_reg(`DN_REG_NOISE, rd);
		compare_val("noise_level", 32'(rd), 32'(model_noise));

		send_frame(WIDE, NARROW, 2'd1);
		wait_for(DRAINED, "the output of frame 2");

		// Back-pressure on the output during frame 3
		toggle_ready = 1'b1;
		send_frame(FLAT, WIDE, 2'd2);
		wait_for(DRAINED, "the output of frame 3");
		toggle_ready = 1'b0;

		foreach (frame_beats[f])
			compare_val("out_beats", 32'(frame_beats[f]), 32'(2 * `DN_BLK_PIX));

		// Input side reopens once the last block has left
		@(negedge clk);
		compare_val("s_axis_tready", 32'(s_axis_tready), 32'(1));
		compare_val("m_axis_tvalid", 32'(m_axis_tvalid), 32'(0));
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: denoise.f
+incdir+verilog
+incdir+verif
verilog/denoise_pkg.sv
verilog/denoise_regs.sv
verilog/block_stats.sv
verilog/noise_estimator.sv
verilog/wiener_filter.sv
verilog/denoise_top.sv
verif/denoise_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the denoiser testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module denoise_tb \
	-f denoise.f \
	-o denoise_sim

./obj_dir/denoise_sim
